/* hdl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int WORD_W   = 32;
    localparam int REG_AW   = 5;
    localparam int OPCODE_W = 6;
    localparam int SHAMT_W  = 5;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_W-1:0]   pc_t;        // Byte address
    typedef logic [7:0]          byte_t;
    typedef logic [REG_AW-1:0]   reg_addr_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [OPCODE_W-1:0] funct_t;
    typedef logic [SHAMT_W-1:0]  shamt_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;

    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_e;

    typedef enum logic {LOAD_IDLE, LOAD_ACK} load_state_e;

endpackage

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import mips_pkg::*;
#(
    parameter int IMEM_WORDS = 64
) (
    input  wire         i_clock,
    input  wire         i_rst_n,
    input  wire         i_pc_enable,
    input  wire         i_load_req,
    input  wire byte_t  i_load_data,
    output logic        o_load_ack,
    output word_t       o_instr
);

    localparam int IDX_W  = $clog2(IMEM_WORDS);
    localparam int ADDR_W = IDX_W + 2;    // Byte address bits

    word_t             imem [IMEM_WORDS];
    load_state_e       load_state;
    logic [ADDR_W-1:0] load_addr;
    logic              load_wr;
    pc_t               pc;
    word_t             fetch_word;

    // Only accept bytes while the core is stopped
    assign load_wr    = (load_state == LOAD_IDLE) && i_load_req && !i_pc_enable;
    assign o_load_ack = (load_state == LOAD_ACK);

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            load_state <= LOAD_IDLE;
            load_addr  <= '0;
        end else begin
            case (load_state)
                LOAD_IDLE: begin
                    if (load_wr) begin
                        load_state <= LOAD_ACK;
                        load_addr  <= load_addr + 1'b1;
                    end
                end
                LOAD_ACK: begin
                    if (!i_load_req) begin
                        load_state <= LOAD_IDLE;
                    end
                end
                default: load_state <= LOAD_IDLE;
            endcase
        end
    end

    // Little-endian byte lanes
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < IMEM_WORDS; i++) begin
                imem[i] <= '0;
            end
        end else if (load_wr) begin
            imem[load_addr[ADDR_W-1:2]][{load_addr[1:0], 3'b000} +: 8] <= i_load_data;
        end
    end

    // Past the end of memory reads as a no-op
    assign fetch_word = (pc[WORD_W-1:ADDR_W] == '0) ? imem[pc[ADDR_W-1:2]] : '0;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc      <= '0;
            o_instr <= '0;
        end else begin
            o_instr <= i_pc_enable ? fetch_word : '0;
            if (i_pc_enable) begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
    import mips_pkg::*;
(
    input  wire             i_clock,
    input  wire             i_rst_n,
    input  wire reg_addr_t  i_rs_addr,
    input  wire reg_addr_t  i_rt_addr,
    input  wire reg_addr_t  i_wr_addr,
    input  wire             i_wr_en,
    input  wire word_t      i_wr_data,
    output word_t           o_rs_data,
    output word_t           o_rt_data
);

    word_t regs [32];

    // Write-through so decode sees this cycle's writeback
    function automatic word_t read_port(reg_addr_t addr);
        if (i_wr_en && (addr == i_wr_addr) && (addr != '0)) begin
            return i_wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin    // r0 stays zero
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    always_comb begin
        o_rs_data = read_port(i_rs_addr);
        o_rt_data = read_port(i_rt_addr);
    end

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import mips_pkg::*;
(
    input  wire         i_clock,
    input  wire         i_rst_n,
    input  wire word_t  i_instr,
    input  wire word_t  i_rs_data,
    input  wire word_t  i_rt_data,
    output reg_addr_t   o_rs_addr,
    output reg_addr_t   o_rt_addr,
    output alu_op_e     o_alu_op,
    output word_t       o_op_a,
    output word_t       o_op_b,
    output shamt_t      o_shamt,
    output reg_addr_t   o_dest,
    output logic        o_wr_en
);

    opcode_t     opcode;
    funct_t      funct;
    shamt_t      shamt;
    reg_addr_t   rd;
    logic [15:0] imm;
    alu_op_e     alu_op;
    logic        use_imm;
    logic        sign_ext;
    logic        kept;
    reg_addr_t   dest;
    word_t       imm_ext;

    assign opcode    = i_instr[31:26];
    assign o_rs_addr = i_instr[25:21];
    assign o_rt_addr = i_instr[20:16];
    assign rd        = i_instr[15:11];
    assign shamt     = i_instr[10:6];
    assign funct     = i_instr[5:0];
    assign imm       = i_instr[15:0];

    always_comb begin
        alu_op   = ALU_ADD;
        use_imm  = 1'b1;
        sign_ext = 1'b0;
        kept     = 1'b1;
        case (opcode)
            OP_RTYPE: begin
                use_imm = 1'b0;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    default: kept = 1'b0;
                endcase
            end
            OP_ADDI: sign_ext = 1'b1;
            OP_SLTI: begin
                alu_op   = ALU_SLT;
                sign_ext = 1'b1;
            end
            OP_ANDI: alu_op = ALU_AND;
            OP_ORI:  alu_op = ALU_OR;
            OP_XORI: alu_op = ALU_XOR;
            OP_LUI:  alu_op = ALU_LUI;
            default: kept = 1'b0;    // Unknown opcodes are no-ops
        endcase
    end

    assign dest    = use_imm ? o_rt_addr : rd;
    assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= kept && (dest != '0);
        end
    end

    // ID/EX payload
    always_ff @(posedge i_clock) begin
        o_alu_op <= alu_op;
        o_op_a   <= i_rs_data;
        o_op_b   <= use_imm ? imm_ext : i_rt_data;
        o_shamt  <= shamt;
        o_dest   <= dest;
    end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import mips_pkg::*;
(
    input  wire             i_clock,
    input  wire             i_rst_n,
    input  wire alu_op_e    i_alu_op,
    input  wire word_t      i_op_a,
    input  wire word_t      i_op_b,
    input  wire shamt_t     i_shamt,
    input  wire reg_addr_t  i_dest,
    input  wire             i_wr_en,
    output word_t           o_result,
    output reg_addr_t       o_dest,
    output logic            o_wr_en
);

    word_t alu_result;

    always_comb begin
        case (i_alu_op)
            ALU_ADD: alu_result = i_op_a + i_op_b;
            ALU_SUB: alu_result = i_op_a - i_op_b;
            ALU_AND: alu_result = i_op_a & i_op_b;
            ALU_OR:  alu_result = i_op_a | i_op_b;
            ALU_XOR: alu_result = i_op_a ^ i_op_b;
            ALU_NOR: alu_result = ~(i_op_a | i_op_b);
            ALU_SLT: begin
                alu_result = {31'd0, $signed(i_op_a) < $signed(i_op_b)};
            end
            ALU_SLL: alu_result = i_op_b << i_shamt;    // Shifts act on rt
            ALU_SRL: alu_result = i_op_b >> i_shamt;
            ALU_LUI: alu_result = {i_op_b[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= i_wr_en;
        end
    end

    // EX/WB payload
    always_ff @(posedge i_clock) begin
        o_result <= alu_result;
        o_dest   <= i_dest;
    end

endmodule

`default_nettype wire

/* hdl/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
    import mips_pkg::*;
(
    input  wire             i_clock,
    input  wire             i_rst_n,
    input  wire word_t      i_result,
    input  wire reg_addr_t  i_dest,
    input  wire             i_wr_en,
    output logic            o_rf_wr_en,
    output reg_addr_t       o_rf_wr_addr,
    output word_t           o_rf_wr_data,
    output word_t           o_result,
    output reg_addr_t       o_result_dest,
    output logic            o_result_valid
);

    // Register file write port straight from EX/WB
    assign o_rf_wr_en   = i_wr_en;
    assign o_rf_wr_addr = i_dest;
    assign o_rf_wr_data = i_result;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= i_wr_en;    // One pulse per retired write
        end
    end

    always_ff @(posedge i_clock) begin
        o_result      <= i_result;
        o_result_dest <= i_dest;
    end

endmodule

`default_nettype wire

/* hdl/mips_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline
    import mips_pkg::*;
#(
    parameter int IMEM_WORDS = 64
) (
    input  wire         i_clock,
    input  wire         i_rst_n,
    input  wire         i_pc_enable,
    input  wire         i_load_req,
    input  wire byte_t  i_load_data,
    output logic        o_load_ack,
    output word_t       o_result,
    output reg_addr_t   o_result_dest,
    output logic        o_result_valid
);

    // IF to ID
    word_t     if_instr;

    // ID and register file
    reg_addr_t id_rs_addr;
    reg_addr_t id_rt_addr;
    word_t     id_rs_data;
    word_t     id_rt_data;

    // ID to EX
    alu_op_e   ex_alu_op;
    word_t     ex_op_a;
    word_t     ex_op_b;
    shamt_t    ex_shamt;
    reg_addr_t ex_dest;
    logic      ex_wr_en;

    // EX to WB
    word_t     wb_result;
    reg_addr_t wb_dest;
    logic      wb_wr_en;

    // WB to register file
    logic      rf_wr_en;
    reg_addr_t rf_wr_addr;
    word_t     rf_wr_data;

    fetch_stage #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_fetch_stage (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_pc_enable (i_pc_enable),
        .i_load_req  (i_load_req),
        .i_load_data (i_load_data),
        .o_load_ack  (o_load_ack),
        .o_instr     (if_instr)
    );

    register_file u_register_file (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_rs_addr (id_rs_addr),
        .i_rt_addr (id_rt_addr),
        .i_wr_addr (rf_wr_addr),
        .i_wr_en   (rf_wr_en),
        .i_wr_data (rf_wr_data),
        .o_rs_data (id_rs_data),
        .o_rt_data (id_rt_data)
    );

    decode_stage u_decode_stage (
        .i_clock   (i_clock),
        .i_rst_n   (i_rst_n),
        .i_instr   (if_instr),
        .i_rs_data (id_rs_data),
        .i_rt_data (id_rt_data),
        .o_rs_addr (id_rs_addr),
        .o_rt_addr (id_rt_addr),
        .o_alu_op  (ex_alu_op),
        .o_op_a    (ex_op_a),
        .o_op_b    (ex_op_b),
        .o_shamt   (ex_shamt),
        .o_dest    (ex_dest),
        .o_wr_en   (ex_wr_en)
    );

    execute_stage u_execute_stage (
        .i_clock  (i_clock),
        .i_rst_n  (i_rst_n),
        .i_alu_op (ex_alu_op),
        .i_op_a   (ex_op_a),
        .i_op_b   (ex_op_b),
        .i_shamt  (ex_shamt),
        .i_dest   (ex_dest),
        .i_wr_en  (ex_wr_en),
        .o_result (wb_result),
        .o_dest   (wb_dest),
        .o_wr_en  (wb_wr_en)
    );

    writeback_stage u_writeback_stage (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_result       (wb_result),
        .i_dest         (wb_dest),
        .i_wr_en        (wb_wr_en),
        .o_rf_wr_en     (rf_wr_en),
        .o_rf_wr_addr   (rf_wr_addr),
        .o_rf_wr_data   (rf_wr_data),
        .o_result       (o_result),
        .o_result_dest  (o_result_dest),
        .o_result_valid (o_result_valid)
    );

endmodule

`default_nettype wire

/* bench/tb_mips_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_pipeline
    import mips_pkg::*;
();

    localparam int          CLK_PERIOD = 10;
    localparam int          IMEM_WORDS = 64;
    localparam int          ACK_WAIT   = 16;    // Cycles allowed per handshake edge
    localparam int          DRAIN      = 16;
    localparam logic [31:0] SEED       = 32'h5915648a;

    logic      i_clock;
    logic      i_rst_n;
    logic      i_pc_enable;
    logic      i_load_req;
    byte_t     i_load_data;
    logic      o_load_ack;
    word_t     o_result;
    reg_addr_t o_result_dest;
    logic      o_result_valid;

    word_t     program_words [$];
    reg_addr_t exp_dest [$];
    word_t     exp_value [$];
    word_t     model_regs [32];
    int        result_count = 0;
    logic      prog_built = 1'b0;

    mips_pipeline #(
        .IMEM_WORDS (IMEM_WORDS)
    ) i_mips_pipeline (
        .i_clock        (i_clock),
        .i_rst_n        (i_rst_n),
        .i_pc_enable    (i_pc_enable),
        .i_load_req     (i_load_req),
        .i_load_data    (i_load_data),
        .o_load_ack     (o_load_ack),
        .o_result       (o_result),
        .o_result_dest  (o_result_dest),
        .o_result_valid (o_result_valid)
    );

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAIL at %0t: %s got %h, expected %h",
                                        $time, name, got, expected));
        end
    endtask

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = $urandom;
        return r[15:0];
    endfunction

    function automatic shamt_t rand5();
        logic [31:0] r;
        r = $urandom;
        return r[4:0];
    endfunction

    // Reference model retires in program order
    task automatic record_result(input reg_addr_t dest, input word_t value);
        if (dest != '0) begin
            model_regs[dest] = value;
            exp_dest.push_back(dest);
            exp_value.push_back(value);
        end
    endtask

    task automatic add_itype(input opcode_t op, input reg_addr_t rt, input reg_addr_t rs,
                             input logic [15:0] imm);
        word_t sext;
        word_t zext;
        word_t a;
        word_t value;
        logic  writes;
        sext   = {{16{imm[15]}}, imm};
        zext   = {16'h0000, imm};
        a      = model_regs[rs];
        value  = '0;
        writes = 1'b1;
        case (op)
            OP_ADDI: value = a + sext;
            OP_SLTI: value = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            OP_ANDI: value = a & zext;
            OP_ORI:  value = a | zext;
            OP_XORI: value = a ^ zext;
            OP_LUI:  value = {imm, 16'h0000};
            default: writes = 1'b0;
        endcase
        program_words.push_back({op, rs, rt, imm});
        if (writes) begin
            record_result(rt, value);
        end
    endtask

    task automatic add_rtype(input funct_t fn, input reg_addr_t rd, input reg_addr_t rs,
                             input reg_addr_t rt, input shamt_t sh);
        word_t a;
        word_t b;
        word_t value;
        a     = model_regs[rs];
        b     = model_regs[rt];
        value = '0;
        case (fn)
            FN_ADDU: value = a + b;
            FN_SUBU: value = a - b;
            FN_AND:  value = a & b;
            FN_OR:   value = a | b;
            FN_XOR:  value = a ^ b;
            FN_NOR:  value = ~(a | b);
            FN_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLL:  value = b << sh;
            FN_SRL:  value = b >> sh;
            default: value = '0;
        endcase
        program_words.push_back({OP_RTYPE, rs, rt, rd, sh, fn});
        record_result(rd, value);
    endtask

    // Every consumer sits two or more slots after its producer
    task automatic build_program();
        logic [15:0] imm_neg;
        logic [15:0] imm_hi;
        imm_neg = rand16() | 16'h8000;
        imm_hi  = rand16() | 16'h8000;
        add_itype(OP_ADDI, 5'd1, 5'd0, imm_neg);      // Negative, sign-extended
        add_itype(OP_ORI,  5'd2, 5'd0, rand16() | 16'h8000);
        add_itype(OP_LUI,  5'd3, 5'd0, rand16());
        add_itype(OP_ADDI, 5'd4, 5'd0, rand16());
        add_itype(OP_ANDI, 5'd5, 5'd1, rand16() | 16'h8000);
        add_itype(OP_XORI, 5'd6, 5'd1, imm_hi);       // High bit must not extend
        add_itype(OP_SLTI, 5'd7, 5'd0, 16'hffff);     // 0 against -1
        add_itype(OP_ORI,  5'd8, 5'd3, rand16());
        add_rtype(FN_ADDU, 5'd9,  5'd2, 5'd4, 5'd0);
        add_rtype(FN_SUBU, 5'd10, 5'd8, 5'd1, 5'd0);
        add_rtype(FN_AND,  5'd11, 5'd8, 5'd6, 5'd0);
        add_rtype(FN_OR,   5'd12, 5'd1, 5'd2, 5'd0);
        add_rtype(FN_XOR,  5'd13, 5'd8, 5'd4, 5'd0);
        add_rtype(FN_NOR,  5'd14, 5'd3, 5'd2, 5'd0);
        add_rtype(FN_SLT,  5'd15, 5'd1, 5'd2, 5'd0);   // Negative against positive
        add_rtype(FN_SLT,  5'd16, 5'd2, 5'd1, 5'd0);
        add_rtype(FN_SLL,  5'd17, 5'd0, 5'd8, rand5() | 5'd1);
        add_rtype(FN_SRL,  5'd18, 5'd0, 5'd1, rand5() | 5'd1);   // Logical on a negative value
        add_itype(OP_ADDI, 5'd0, 5'd8, 16'h0005);         // r0 writes stay silent
        add_rtype(FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0);
        add_rtype(FN_OR,   5'd19, 5'd0, 5'd9, 5'd0);
        add_itype(OP_ADDI, 5'd20, 5'd0, rand16());
        add_itype(OP_XORI, 5'd22, 5'd4, rand16());
        add_rtype(FN_ADDU, 5'd21, 5'd19, 5'd20, 5'd0);    // Exactly two slots after r20
        program_words.push_back({6'h23, 5'd1, 5'd23, 16'h0000});  // Old load opcode
        add_rtype(FN_SUBU, 5'd23, 5'd21, 5'd22, 5'd0);
    endtask

    task automatic load_byte(input byte_t value);
        int waited;
        waited      = 0;
        i_load_data = value;
        i_load_req  = 1'b1;
        while (!o_load_ack) begin
            @(posedge i_clock);
            #1;
            waited++;
            if (waited > ACK_WAIT) begin
                stop_with_failure("Loader: o_load_ack did not rise after the request");
            end
        end
        i_load_req = 1'b0;
        waited     = 0;
        while (o_load_ack) begin
            @(posedge i_clock);
            #1;
            waited++;
            if (waited > ACK_WAIT) begin
                stop_with_failure("Loader: o_load_ack stayed high after the request dropped");
            end
        end
    endtask

    always @(negedge i_clock) begin
        if (i_rst_n && o_result_valid) begin
            if (result_count >= exp_value.size()) begin
                stop_with_failure("More results arrived than the program produces");
            end else begin
                check_value("o_result_dest", {27'd0, o_result_dest},
                            {27'd0, exp_dest[result_count]});
                check_value("o_result", o_result, exp_value[result_count]);
                result_count++;
            end
        end
    end

    initial begin
        wait (prog_built);
        #((program_words.size() * 8 + program_words.size() * 4 * (2 * ACK_WAIT + 2) + 20)
          * CLK_PERIOD);
        stop_with_failure("Watchdog expired before the run completed");
    end

    initial begin
        word_t word;
        i_clock     = 1'b0;
        i_rst_n     = 1'b0;
        i_pc_enable = 1'b0;
        i_load_req  = 1'b0;
        i_load_data = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        void'($urandom(SEED));
        build_program();
        prog_built = 1'b1;

        repeat (3) @(posedge i_clock);
        #1 i_rst_n = 1'b1;
        check_value("o_load_ack", {31'd0, o_load_ack}, '0);

        foreach (program_words[i]) begin
            word = program_words[i];
            for (int b = 0; b < 4; b++) begin
                load_byte(word[8*b +: 8]);    // Little-endian
            end
        end

        @(posedge i_clock);
        #1 i_pc_enable = 1'b1;
        repeat (program_words.size() + DRAIN) @(posedge i_clock);
        #1;
        if (result_count != exp_value.size()) begin
            stop_with_failure($sformatf("Only %0d of %0d expected results arrived",
                                        result_count, exp_value.size()));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/mips_pipeline.sv
bench/tb_mips_pipeline.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = tb_mips_pipeline
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
